/* src/game_pkg.sv */
package game_pkg;

    // One-hot game states, one bit per state.
    typedef enum logic [6:0]
    {
        START    = 7'b000_0001,
        AIM      = 7'b000_0010,
        SHOOT    = 7'b000_0100,
        WON      = 7'b000_1000,
        WON_END  = 7'b001_0000,
        LOST     = 7'b010_0000,
        LOST_END = 7'b100_0000
    } game_state_t;

    // Signed screen coordinate. Negative values lie past the left or top edge.
    typedef logic signed [10:0] coord_t;

endpackage

/* src/sprite_if.sv */
interface sprite_if;

    import game_pkg::*;

    logic   write_xy;                   // Load the start position and stop the sprite.
    logic   write_dxy;                  // Load the sprite velocity.
    logic   enable_update;              // Let the sprite move.

    coord_t x;
    coord_t y;
    logic   within_screen;              // The whole box is on screen.

    modport control
    (
        output write_xy,
        output write_dxy,
        output enable_update,
        input  within_screen
    );

    modport mover
    (
        input  write_xy,
        input  write_dxy,
        input  enable_update,
        output x,
        output y,
        output within_screen
    );

    modport observe
    (
        input  x,
        input  y
    );

endinterface

/* src/game_master_fsm.sv */
module game_master_fsm
(
    input  logic      clk,
    input  logic      reset,
    input  logic      key,
    input  logic      collision,
    input  logic      timer_running,
    output logic      timer_start,
    output logic      game_won,
    sprite_if.control target,
    sprite_if.control torpedo
);

    import game_pkg::*;

    game_state_t state;
    game_state_t next_state;
    logic        out_of_screen;
    logic        positions_live;            // The sprites were in play in the last cycle.

    assign out_of_screen = !target.within_screen || !torpedo.within_screen;

    always_comb
    begin
        next_state = state;

        case (state)
            START:
            begin
                // After reset the load strobes are still low, so START waits one
                // more cycle for them. On every later entry they are already up.
                if (target.write_xy)
                    next_state = AIM;
            end
            AIM:
            begin
                // In the first AIM cycle the collision register still holds the
                // frozen positions of the last game.
                if (out_of_screen)
                    next_state = LOST;
                else if (collision && positions_live)
                    next_state = WON;
                else if (key)
                    next_state = SHOOT;
            end
            SHOOT:
            begin
                if (out_of_screen)
                    next_state = LOST;
                else if (collision && positions_live)
                    next_state = WON;
            end
            WON:
                next_state = WON_END;
            WON_END:
            begin
                if (!timer_running)
                    next_state = START;
            end
            LOST:
                next_state = LOST_END;
            LOST_END:
            begin
                if (!timer_running)
                    next_state = START;
            end
            default:
                next_state = START;         // Recover from a broken one-hot code.
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state          <= START;
            positions_live <= 1'b0;
        end
        else
        begin
            state          <= next_state;
            positions_live <= (state == AIM) || (state == SHOOT);
        end
    end

    // Outputs come from the next state so they change together with the state.
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            target.write_xy       <= 1'b0;
            torpedo.write_xy      <= 1'b0;
            target.write_dxy      <= 1'b0;
            torpedo.write_dxy     <= 1'b0;
            target.enable_update  <= 1'b0;
            torpedo.enable_update <= 1'b0;
            timer_start           <= 1'b0;
            game_won              <= 1'b0;
        end
        else
        begin
            target.write_xy       <= 1'b0;
            torpedo.write_xy      <= 1'b0;
            target.write_dxy      <= 1'b0;
            torpedo.write_dxy     <= 1'b0;
            target.enable_update  <= 1'b0;
            torpedo.enable_update <= 1'b0;
            timer_start           <= 1'b0;
            game_won              <= (next_state == WON) || (next_state == WON_END);

            case (next_state)
                START:
                begin
                    target.write_xy  <= 1'b1;
                    torpedo.write_xy <= 1'b1;
                    target.write_dxy <= 1'b1;
                end
                AIM:
                    target.enable_update <= 1'b1;
                SHOOT:
                begin
                    target.enable_update  <= 1'b1;
                    torpedo.enable_update <= 1'b1;
                    if (state != SHOOT)
                        torpedo.write_dxy <= 1'b1;  // Launch on the entry cycle only.
                end
                WON, LOST:
                    timer_start <= 1'b1;
                default:
                begin
                end
            endcase
        end
    end

endmodule

/* src/sprite_mover.sv */
module sprite_mover
#(
    parameter int SCREEN_W     = 640,
    parameter int SCREEN_H     = 480,
    parameter int SPRITE_SIZE  = 8,
    parameter int STEP_DIVIDER = 4,
    parameter int START_X      = 0,
    parameter int START_Y      = 0,
    parameter int DX           = 0,
    parameter int DY           = 0
)
(
    input logic     clk,
    input logic     reset,
    sprite_if.mover s
);

    import game_pkg::*;

    localparam int CNT_W = (STEP_DIVIDER > 1) ? $clog2(STEP_DIVIDER) : 1;

    coord_t           dx;
    coord_t           dy;
    logic [CNT_W-1:0] step_cnt;
    logic             step;

    // One motion step on the last enabled cycle of each prescaler period.
    assign step = s.enable_update && (step_cnt == CNT_W'(STEP_DIVIDER - 1));

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            step_cnt <= '0;
        else if (!s.enable_update || step)
            step_cnt <= '0;
        else
            step_cnt <= step_cnt + 1'b1;
    end

    // A velocity load wins over the clear that comes with a position load.
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            dx <= '0;
            dy <= '0;
        end
        else if (s.write_dxy)
        begin
            dx <= coord_t'(DX);
            dy <= coord_t'(DY);
        end
        else if (s.write_xy)
        begin
            dx <= '0;
            dy <= '0;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            s.x <= '0;
            s.y <= '0;
        end
        else if (s.write_xy)
        begin
            s.x <= coord_t'(START_X);
            s.y <= coord_t'(START_Y);
        end
        else if (step)
        begin
            s.x <= s.x + dx;
            s.y <= s.y + dy;
        end
    end

    assign s.within_screen = (s.x >= 0) && (s.y >= 0)
                          && (int'(s.x) + SPRITE_SIZE <= SCREEN_W)
                          && (int'(s.y) + SPRITE_SIZE <= SCREEN_H);

endmodule

/* src/collision_detector.sv */
module collision_detector
#(
    parameter int SPRITE_SIZE = 8
)
(
    input  logic       clk,
    input  logic       reset,
    sprite_if.observe  a,
    sprite_if.observe  b,
    output logic       collision
);

    logic overlap_x;
    logic overlap_y;

    // Two squares of the same size overlap when each starts before the other ends.
    assign overlap_x = (int'(a.x) < int'(b.x) + SPRITE_SIZE)
                    && (int'(b.x) < int'(a.x) + SPRITE_SIZE);

    assign overlap_y = (int'(a.y) < int'(b.y) + SPRITE_SIZE)
                    && (int'(b.y) < int'(a.y) + SPRITE_SIZE);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            collision <= 1'b0;
        else
            collision <= overlap_x && overlap_y;
    end

endmodule

/* src/end_of_game_timer.sv */
module end_of_game_timer
#(
    parameter int END_CYCLES = 16
)
(
    input  logic clk,
    input  logic reset,
    input  logic start,
    output logic running
);

    localparam int CNT_W = $clog2(END_CYCLES + 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            count <= '0;
        else if (start)
            count <= CNT_W'(END_CYCLES);   // A new start restarts the pause.
        else if (count != '0)
            count <= count - 1'b1;
    end

    assign running = (count != '0);

endmodule

/* src/game_top.sv */
module game_top
#(
    parameter int SCREEN_W        = 640,
    parameter int SCREEN_H        = 480,
    parameter int SPRITE_SIZE     = 8,
    parameter int STEP_DIVIDER    = 4,
    parameter int END_CYCLES      = 16,
    parameter int TARGET_START_X  = 0,
    parameter int TARGET_START_Y  = 40,
    parameter int TARGET_DX       = 2,
    parameter int TARGET_DY       = 0,
    parameter int TORPEDO_START_X = 316,
    parameter int TORPEDO_START_Y = 440,
    parameter int TORPEDO_DX      = 0,
    parameter int TORPEDO_DY      = -4
)
(
    input  logic             clk,
    input  logic             reset,
    input  logic             key,
    output game_pkg::coord_t target_x,
    output game_pkg::coord_t target_y,
    output game_pkg::coord_t torpedo_x,
    output game_pkg::coord_t torpedo_y,
    output logic             game_won,
    output logic             game_over
);

    logic collision;
    logic timer_start;
    logic timer_running;

    sprite_if target_sprite ();
    sprite_if torpedo_sprite ();

    game_master_fsm i_fsm
    (
        .clk           (clk),
        .reset         (reset),
        .key           (key),
        .collision     (collision),
        .timer_running (timer_running),
        .timer_start   (timer_start),
        .game_won      (game_won),
        .target        (target_sprite.control),
        .torpedo       (torpedo_sprite.control)
    );

    sprite_mover
    #(
        .SCREEN_W     (SCREEN_W),
        .SCREEN_H     (SCREEN_H),
        .SPRITE_SIZE  (SPRITE_SIZE),
        .STEP_DIVIDER (STEP_DIVIDER),
        .START_X      (TARGET_START_X),
        .START_Y      (TARGET_START_Y),
        .DX           (TARGET_DX),
        .DY           (TARGET_DY)
    )
    i_target_mover
    (
        .clk   (clk),
        .reset (reset),
        .s     (target_sprite.mover)
    );

    sprite_mover
    #(
        .SCREEN_W     (SCREEN_W),
        .SCREEN_H     (SCREEN_H),
        .SPRITE_SIZE  (SPRITE_SIZE),
        .STEP_DIVIDER (STEP_DIVIDER),
        .START_X      (TORPEDO_START_X),
        .START_Y      (TORPEDO_START_Y),
        .DX           (TORPEDO_DX),
        .DY           (TORPEDO_DY)
    )
    i_torpedo_mover
    (
        .clk   (clk),
        .reset (reset),
        .s     (torpedo_sprite.mover)
    );

    collision_detector #(.SPRITE_SIZE (SPRITE_SIZE)) i_collision
    (
        .clk       (clk),
        .reset     (reset),
        .a         (target_sprite.observe),
        .b         (torpedo_sprite.observe),
        .collision (collision)
    );

    end_of_game_timer #(.END_CYCLES (END_CYCLES)) i_timer
    (
        .clk     (clk),
        .reset   (reset),
        .start   (timer_start),
        .running (timer_running)
    );

    assign target_x  = target_sprite.x;
    assign target_y  = target_sprite.y;
    assign torpedo_x = torpedo_sprite.x;
    assign torpedo_y = torpedo_sprite.y;
    assign game_over = timer_running;     // High during the pause after a game.

endmodule

/* bench/game_assertions.sv */
module game_assertions
#(
    parameter int SCREEN_W        = 1,
    parameter int SCREEN_H        = 1,
    parameter int SPRITE_SIZE     = 1,
    parameter int STEP_DIVIDER    = 1,
    parameter int END_CYCLES      = 1,
    parameter int TARGET_START_X  = 0,
    parameter int TARGET_START_Y  = 0,
    parameter int TARGET_DX       = 0,
    parameter int TORPEDO_START_X = 0,
    parameter int TORPEDO_START_Y = 0,
    parameter int TORPEDO_DY      = 0
)
(
    input logic                  clk,
    input logic                  reset,
    input logic                  key,
    input logic                  collision,
    input logic                  timer_start,
    input game_pkg::game_state_t state,
    input game_pkg::coord_t      target_x,
    input game_pkg::coord_t      target_y,
    input game_pkg::coord_t      torpedo_x,
    input game_pkg::coord_t      torpedo_y,
    input logic                  game_won,
    input logic                  game_over
);

    timeunit 1ns;
    timeprecision 1ps;

    import game_pkg::*;

    int   failure_count = 0;                // Read by the testbench for its summary.
    logic playing;
    logic game_ended;
    logic both_on_screen;
    logic boxes_overlap;

    function automatic int distance(input coord_t a, input coord_t b);
        int d;
        d = int'(a) - int'(b);
        return (d < 0) ? -d : d;
    endfunction

    // The top left corner may range from 0 to the screen size less the box size.
    function automatic logic fits_on_screen(input coord_t x, input coord_t y);
        return (x >= 0) && (y >= 0) && (int'(x) <= SCREEN_W - SPRITE_SIZE)
            && (int'(y) <= SCREEN_H - SPRITE_SIZE);
    endfunction

    task automatic record_failure(input string what);
        failure_count++;
        $error("[ERROR] %0d ns: %s", $time, what);
    endtask

    assign playing        = (state == AIM) || (state == SHOOT);
    assign game_ended     = (state == WON) || (state == WON_END) || (state == LOST)
                         || (state == LOST_END);
    assign both_on_screen = fits_on_screen(target_x, target_y)
                         && fits_on_screen(torpedo_x, torpedo_y);
    assign boxes_overlap  = (distance(target_x, torpedo_x) < SPRITE_SIZE)
                         && (distance(target_y, torpedo_y) < SPRITE_SIZE);

    idle_in_start: assert property (@(posedge clk) disable iff (reset)
        state == START |-> !game_won && !game_over)
        else record_failure("game_won or game_over is high in START");

    // The first AIM cycle sees the positions loaded by START.
    start_positions: assert property (@(posedge clk) disable iff (reset)
        state == AIM && $past(state) == START |->
            int'(target_x) == TARGET_START_X && int'(target_y) == TARGET_START_Y
            && int'(torpedo_x) == TORPEDO_START_X && int'(torpedo_y) == TORPEDO_START_Y)
        else record_failure("sprites are not at their start positions after START");

    torpedo_parked: assert property (@(posedge clk) disable iff (reset)
        state == AIM |->
            int'(torpedo_x) == TORPEDO_START_X && int'(torpedo_y) == TORPEDO_START_Y)
        else record_failure("torpedo moved before launch");

    // Exactly one target step in every window of STEP_DIVIDER cycles of play.
    target_pace: assert property (@(posedge clk) disable iff (reset)
        playing && $past(playing, STEP_DIVIDER) |->
            int'(target_x) - int'($past(target_x, STEP_DIVIDER)) == TARGET_DX
            && target_y == $past(target_y, STEP_DIVIDER))
        else record_failure("target did not advance by DX per step period");

    torpedo_pace: assert property (@(posedge clk) disable iff (reset)
        state == SHOOT && $past(state == SHOOT, STEP_DIVIDER) |->
            int'(torpedo_y) - int'($past(torpedo_y, STEP_DIVIDER)) == TORPEDO_DY
            && torpedo_x == $past(torpedo_x, STEP_DIVIDER))
        else record_failure("torpedo did not advance by DY per step period");

    launch: assert property (@(posedge clk) disable iff (reset)
        state == AIM && key && !collision && both_on_screen |=> state == SHOOT)
        else record_failure("key press in AIM did not launch the torpedo");

    // One cycle in the collision register, one in the FSM output register.
    win_after_overlap: assert property (@(posedge clk) disable iff (reset)
        $past(playing && boxes_overlap && both_on_screen, 2) |-> game_won)
        else record_failure("game_won missing two cycles after an overlap");

    // The overlap must belong to the running game, not to the frozen end positions.
    won_needs_overlap: assert property (@(posedge clk) disable iff (reset)
        $rose(game_won) |-> $past(playing && boxes_overlap, 2))
        else record_failure("game_won rose without an earlier overlap");

    won_then_pause: assert property (@(posedge clk) disable iff (reset)
        $rose(game_won) |=> $rose(game_over))
        else record_failure("game_over did not follow game_won");

    loss_reported: assert property (@(posedge clk) disable iff (reset)
        $past(playing && !both_on_screen, 2) |-> $rose(game_over) && !game_won)
        else record_failure("a sprite left the screen without a lost game");

    pause_start: assert property (@(posedge clk) disable iff (reset)
        $rose(game_over) |-> $past(timer_start) && (state == WON_END || state == LOST_END))
        else record_failure("game_over rose outside an end state");

    pause_length: assert property (@(posedge clk) disable iff (reset)
        $fell(game_over) |-> $past(game_over, END_CYCLES) && !$past(game_over, END_CYCLES + 1))
        else record_failure("game_over pause has the wrong length");

    frozen_after_game: assert property (@(posedge clk) disable iff (reset)
        game_ended && $past(game_ended) |->
            $stable(target_x) && $stable(target_y) && $stable(torpedo_x) && $stable(torpedo_y))
        else record_failure("a sprite moved after the game ended");

endmodule

bind game_top game_assertions
#(
    .SCREEN_W        (SCREEN_W),
    .SCREEN_H        (SCREEN_H),
    .SPRITE_SIZE     (SPRITE_SIZE),
    .STEP_DIVIDER    (STEP_DIVIDER),
    .END_CYCLES      (END_CYCLES),
    .TARGET_START_X  (TARGET_START_X),
    .TARGET_START_Y  (TARGET_START_Y),
    .TARGET_DX       (TARGET_DX),
    .TORPEDO_START_X (TORPEDO_START_X),
    .TORPEDO_START_Y (TORPEDO_START_Y),
    .TORPEDO_DY      (TORPEDO_DY)
)
i_game_assertions
(
    .clk         (clk),
    .reset       (reset),
    .key         (key),
    .collision   (collision),
    .timer_start (timer_start),
    .state       (i_fsm.state),
    .target_x    (target_x),
    .target_y    (target_y),
    .torpedo_x   (torpedo_x),
    .torpedo_y   (torpedo_y),
    .game_won    (game_won),
    .game_over   (game_over)
);

/* bench/tb_game.sv */
module tb_game;

    timeunit 1ns;
    timeprecision 1ps;

    import game_pkg::*;

    logic        clk;
    logic        reset;
    logic        key;
    coord_t      target_x;
    coord_t      target_y;
    coord_t      torpedo_x;
    coord_t      torpedo_y;
    logic        game_won;
    logic        game_over;

    logic [31:0] lfsr_state;
    int          cycle_count = 0;
    int          cycle_limit;
    int          games_won;
    int          games_lost;

    game_top i_game_top
    (
        .clk       (clk),
        .reset     (reset),
        .key       (key),
        .target_x  (target_x),
        .target_y  (target_y),
        .torpedo_x (torpedo_x),
        .torpedo_y (torpedo_y),
        .game_won  (game_won),
        .game_over (game_over)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;                 // 40 ns period.
    end

    // Galois form of x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] value);
        logic [31:0] shifted;
        shifted = value >> 1;
        if (value[0])
            shifted = shifted ^ 32'h8020_0003;
        return shifted;
    endfunction

    function automatic int random_bits(input int count);
        int value;
        value = 0;
        for (int i = 0; i < count; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);   // One step for each bit taken.
            value = (value << 1) | int'(lfsr_state[0]);
        end
        return value;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // A press value of -1 never matches, so that kind of press is off.
    task automatic play_game(input int press_x, input int press_cycle);
        int aim_cycles;
        aim_cycles = 0;
        while (i_game_top.i_fsm.state != AIM)
            next_cycle();
        while (i_game_top.i_fsm.state == AIM)
        begin
            key = (target_x == press_x) || (aim_cycles == press_cycle);
            next_cycle();
            key = 1'b0;
            aim_cycles++;
        end
        while (!game_over)
            next_cycle();
        if (game_won)
            games_won++;
        else
            games_lost++;
        while (game_over)
            next_cycle();
    endtask

    task automatic finish_run(input bit timed_out);
        int failures;
        failures = i_game_top.i_game_assertions.failure_count;
        $display("Assertion failures: %0d, timeouts: %0d, games won: %0d, games lost: %0d",
                 failures, timed_out, games_won, games_lost);
        if (failures == 0 && !timed_out)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    endtask

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit)
        begin
            $display("Timeout: the games did not finish within %0d clock cycles.", cycle_limit);
            finish_run(1'b1);
        end
    end

    initial
    begin
        int crossing_steps;
        int climb_steps;
        int intercept_x;
        reset      = 1'b1;
        key        = 1'b0;
        lfsr_state = 32'hcdbb_82a5;
        games_won  = 0;
        games_lost = 0;
        crossing_steps = (i_game_top.SCREEN_W - i_game_top.SPRITE_SIZE
                          - i_game_top.TARGET_START_X) / i_game_top.TARGET_DX + 1;
        cycle_limit = 7 * (crossing_steps + i_game_top.END_CYCLES + 16) * i_game_top.STEP_DIVIDER;
        // Steps the torpedo needs to climb to the target row, and where the target is then.
        climb_steps = (i_game_top.TORPEDO_START_Y - i_game_top.TARGET_START_Y)
                      / (-i_game_top.TORPEDO_DY);
        intercept_x = i_game_top.TORPEDO_START_X - i_game_top.TARGET_DX * climb_steps;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        play_game(-1, -1);
        play_game(intercept_x, -1);
        play_game(intercept_x, -1);
        repeat (4) play_game(-1, random_bits(10));
        finish_run(1'b0);
    end

endmodule

/* src.f */
src/game_pkg.sv
src/sprite_if.sv
src/game_master_fsm.sv
src/sprite_mover.sv
src/collision_detector.sv
src/end_of_game_timer.sv
src/game_top.sv
bench/game_assertions.sv
bench/tb_game.sv

/* run.sh */
#!/bin/sh
# Builds the game testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_game -f src.f -o Vtb_game || exit 1
./obj_dir/Vtb_game +verilator+error+limit+100000 > sim.log 2>&1 || sim_failed=1
cat sim.log
grep -q "Test failed" sim.log && exit 1
[ -z "$sim_failed" ] || exit 1
grep -q "Test completed successfully" sim.log || exit 1
exit 0
